/* exec_core.f */
hw/exec_core_pkg.sv
hw/phys_reg_file.sv
hw/alu_unit.sv
hw/mult_unit.sv
hw/cdb_arbiter.sv
hw/exec_core.sv
test/exec_core_tb.sv

/* hw/alu_unit.sv */
//****************************************
// single-cycle integer ALU
// result waits in a holding reg for a CDB grant
//****************************************
`default_nettype none

module alu_unit import exec_core_pkg::*; #(
  parameter  int NUM_PR = 32,
  localparam int TAG_W  = $clog2(NUM_PR)
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             en,
  // issue
  input  logic             alu_issue,
  input  alu_op_t          alu_op,
  input  logic [TAG_W-1:0] alu_dest,
  input  logic [XLEN-1:0]  alu_val1,
  input  logic [XLEN-1:0]  alu_val2,
  input  logic [XLEN-1:0]  alu_imm,
  // arbiter grant
  input  logic             alu_grant,
  // status and completion
  output logic             alu_ready,
  output logic             alu_done,
  output logic [TAG_W-1:0] alu_res_tag,
  output logic [XLEN-1:0]  alu_res_value
);

  localparam int SHAMT_W = $clog2(XLEN);  // 6 bits of shift amount

  logic               hold_valid;  // holding reg occupied
  logic [XLEN-1:0]    result;      // combinational op result
  logic [SHAMT_W-1:0] shamt;
  logic               slt;

  assign shamt = alu_val2[SHAMT_W-1:0];
  assign slt   = $signed(alu_val1) < $signed(alu_val2);  // signed compare

  // opcode decode, operands come straight from the reg file
  always_comb begin
    case (alu_op)
      ALU_ADD:  result = alu_val1 + alu_val2;
      ALU_SUB:  result = alu_val1 - alu_val2;
      ALU_AND:  result = alu_val1 & alu_val2;
      ALU_OR:   result = alu_val1 | alu_val2;
      ALU_XOR:  result = alu_val1 ^ alu_val2;
      ALU_SLL:  result = alu_val1 << shamt;
      ALU_SRL:  result = alu_val1 >> shamt;    // logical, zero fill
      ALU_SLT:  result = XLEN'(slt);           // 0 or 1
      ALU_ADDI: result = alu_val1 + alu_imm;
      default:  result = '0;
    endcase
  end

  // done flag, refill wins over a grant on the same edge
  always_ff @(posedge clock) begin
    if (reset) begin
      hold_valid <= 1'b0;
    end else if (en) begin
      if (alu_issue) begin
        hold_valid <= 1'b1;
      end else if (alu_grant) begin
        hold_valid <= 1'b0;                    // broadcast taken
      end
    end
  end

  // result and tag payload
  always_ff @(posedge clock) begin
    if (en && alu_issue) begin
      alu_res_tag   <= alu_dest;
      alu_res_value <= result;
    end
  end

  // nothing completes while frozen
  assign alu_done  = hold_valid && en;
  // free now, or being drained this cycle
  assign alu_ready = !hold_valid || alu_grant;

endmodule : alu_unit

`default_nettype wire

/* hw/cdb_arbiter.sv */
//****************************************
// common data bus arbiter
// multiplier first, ALU waits its turn
//****************************************
`default_nettype none

module cdb_arbiter import exec_core_pkg::*; #(
  parameter  int NUM_PR = 32,
  localparam int TAG_W  = $clog2(NUM_PR)
) (
  // ALU completion
  input  logic             alu_done,
  input  logic [TAG_W-1:0] alu_res_tag,
  input  logic [XLEN-1:0]  alu_res_value,
  // multiplier completion
  input  logic             mul_done,
  input  logic [TAG_W-1:0] mul_res_tag,
  input  logic [XLEN-1:0]  mul_res_value,
  // grant back to the ALU
  output logic             alu_grant,
  // the single broadcast
  output logic             cdb_valid,
  output logic [TAG_W-1:0] cdb_tag,
  output logic [XLEN-1:0]  cdb_value
);

  logic sel_mul;  // multiplier owns the bus
  logic sel_alu;  // ALU owns the bus

  // fixed priority, multiply can not wait
  assign sel_mul = mul_done;
  assign sel_alu = alu_done && !mul_done;

  assign alu_grant = sel_alu;  // frees the ALU holding reg
  assign cdb_valid = sel_mul || sel_alu;

  // bus mux, idle bus carries zeros
  always_comb begin
    if (sel_mul) begin
      cdb_tag   = mul_res_tag;
      cdb_value = mul_res_value;
    end else if (sel_alu) begin
      cdb_tag   = alu_res_tag;
      cdb_value = alu_res_value;
    end else begin
      cdb_tag   = '0;
      cdb_value = '0;
    end
  end

endmodule : cdb_arbiter

`default_nettype wire

/* hw/exec_core.sv */
//****************************************
// execute and writeback slice
// reg file, ALU, multiplier and CDB arbiter
//****************************************
`default_nettype none

module exec_core import exec_core_pkg::*; #(
  parameter  int NUM_PR = 32,
  localparam int TAG_W  = $clog2(NUM_PR)
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             en,       // global freeze when low
  // ALU issue
  input  logic             alu_issue,
  input  alu_op_t          alu_op,
  input  logic [TAG_W-1:0] alu_dest,
  input  logic [TAG_W-1:0] alu_src1,
  input  logic [TAG_W-1:0] alu_src2,
  input  logic [XLEN-1:0]  alu_imm,
  // multiplier issue
  input  logic             mul_issue,
  input  mul_op_t          mul_op,
  input  logic [TAG_W-1:0] mul_dest,
  input  logic [TAG_W-1:0] mul_src1,
  input  logic [TAG_W-1:0] mul_src2,
  // status and broadcast
  output logic             alu_ready,
  output logic             cdb_valid,
  output logic [TAG_W-1:0] cdb_tag,
  output logic [XLEN-1:0]  cdb_value
);

  logic [XLEN-1:0]  alu_val1, alu_val2;  // operands
  logic [XLEN-1:0]  mul_val1, mul_val2;
  logic             alu_done, alu_grant;
  logic [TAG_W-1:0] alu_res_tag;
  logic [XLEN-1:0]  alu_res_value;
  logic             mul_done;
  logic [TAG_W-1:0] mul_res_tag;
  logic [XLEN-1:0]  mul_res_value;

  phys_reg_file #(.NUM_PR(NUM_PR)) u_prf (
    .clock, .reset, .en,
    .cdb_valid, .cdb_tag, .cdb_value,
    .alu_src1, .alu_src2, .mul_src1, .mul_src2,
    .alu_val1, .alu_val2, .mul_val1, .mul_val2
  );

  alu_unit #(.NUM_PR(NUM_PR)) u_alu (
    .clock, .reset, .en,
    .alu_issue, .alu_op, .alu_dest, .alu_val1, .alu_val2, .alu_imm,
    .alu_grant,
    .alu_ready, .alu_done, .alu_res_tag, .alu_res_value
  );

  mult_unit #(.NUM_PR(NUM_PR)) u_mul (
    .clock, .reset, .en,
    .mul_issue, .mul_op, .mul_dest, .mul_val1, .mul_val2,
    .mul_done, .mul_res_tag, .mul_res_value
  );

  cdb_arbiter #(.NUM_PR(NUM_PR)) u_arb (
    .alu_done, .alu_res_tag, .alu_res_value,
    .mul_done, .mul_res_tag, .mul_res_value,
    .alu_grant,
    .cdb_valid, .cdb_tag, .cdb_value
  );

endmodule : exec_core

`default_nettype wire

/* hw/exec_core_pkg.sv */
//****************************************
// execute core shared types
// data width plus ALU and multiplier opcode enums
//****************************************
`default_nettype none

package exec_core_pkg;

  // integer datapath width
  parameter int XLEN = 64;

  // single-cycle ALU operations
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,  // src1 + src2
    ALU_SUB  = 4'd1,  // src1 - src2
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,  // shift left by src2[5:0]
    ALU_SRL  = 4'd6,  // logical shift right by src2[5:0]
    ALU_SLT  = 4'd7,  // signed less-than, result 0 or 1
    ALU_ADDI = 4'd8   // src1 + imm
  } alu_op_t;

  // multiplier result half select
  typedef enum logic {
    MUL_LO = 1'b0,  // bits 63:0 of the product
    MUL_HI = 1'b1   // bits 127:64 of the product
  } mul_op_t;

  // the product is always unsigned
  // both operands are taken as plain 64-bit magnitudes
  // the 128-bit product is built from four 32x32 pieces

endpackage : exec_core_pkg

`default_nettype wire

/* hw/mult_unit.sv */
//****************************************
// three-stage unsigned 64x64 multiplier
// returns low or high half, never stalls
//****************************************
`default_nettype none

module mult_unit import exec_core_pkg::*; #(
  parameter  int NUM_PR = 32,
  localparam int TAG_W  = $clog2(NUM_PR)
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             en,
  // issue
  input  logic             mul_issue,
  input  mul_op_t          mul_op,
  input  logic [TAG_W-1:0] mul_dest,
  input  logic [XLEN-1:0]  mul_val1,
  input  logic [XLEN-1:0]  mul_val2,
  // completion, always wins the CDB
  output logic             mul_done,
  output logic [TAG_W-1:0] mul_res_tag,
  output logic [XLEN-1:0]  mul_res_value
);

  localparam int HALF = XLEN / 2;  // 32-bit pieces
  localparam int PW   = 2 * XLEN;  // full product width

  // operand halves in the issue cycle
  logic [HALF-1:0] a_lo, a_hi, b_lo, b_hi;

  // stage 1 partial products
  logic             s1_valid;
  logic [TAG_W-1:0] s1_tag;
  mul_op_t          s1_op;
  logic [XLEN-1:0]  s1_ll, s1_lh, s1_hl, s1_hh;

  // stage 2 full product
  logic             s2_valid;
  logic [TAG_W-1:0] s2_tag;
  mul_op_t          s2_op;
  logic [PW-1:0]    s2_prod;

  // stage 3 selected half
  logic             s3_valid;

  assign a_lo = mul_val1[HALF-1:0];
  assign a_hi = mul_val1[XLEN-1:HALF];
  assign b_lo = mul_val2[HALF-1:0];
  assign b_hi = mul_val2[XLEN-1:HALF];

  // valid bits shift every enabled edge
  always_ff @(posedge clock) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end else if (en) begin
      s1_valid <= mul_issue;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
    end
  end

  // datapath, no stall so every stage advances together
  always_ff @(posedge clock) begin
    if (en) begin
      // stage 1 forms four 32x32 products
      s1_tag <= mul_dest;
      s1_op  <= mul_op;
      s1_ll  <= a_lo * b_lo;
      s1_lh  <= a_lo * b_hi;
      s1_hl  <= a_hi * b_lo;
      s1_hh  <= a_hi * b_hi;
      // stage 2 aligns and sums them
      s2_tag  <= s1_tag;
      s2_op   <= s1_op;
      s2_prod <= {s1_hh, s1_ll}
               + (PW'(s1_lh) << HALF)        // cross terms at bit 32
               + (PW'(s1_hl) << HALF);
      // stage 3 picks the half
      mul_res_tag   <= s2_tag;
      mul_res_value <= (s2_op == MUL_HI) ? s2_prod[PW-1:XLEN] : s2_prod[XLEN-1:0];
    end
  end

  assign mul_done = s3_valid && en;  // held back while frozen

endmodule : mult_unit

`default_nettype wire

/* hw/phys_reg_file.sv */
//****************************************
// physical register file
// CDB write port, four forwarding read ports
//****************************************
`default_nettype none

module phys_reg_file import exec_core_pkg::*; #(
  parameter  int NUM_PR = 32,
  localparam int TAG_W  = $clog2(NUM_PR)
) (
  input  logic             clock,
  input  logic             reset,
  input  logic             en,
  // common data bus write
  input  logic             cdb_valid,
  input  logic [TAG_W-1:0] cdb_tag,
  input  logic [XLEN-1:0]  cdb_value,
  // read tags from both units
  input  logic [TAG_W-1:0] alu_src1,
  input  logic [TAG_W-1:0] alu_src2,
  input  logic [TAG_W-1:0] mul_src1,
  input  logic [TAG_W-1:0] mul_src2,
  // operand values
  output logic [XLEN-1:0]  alu_val1,
  output logic [XLEN-1:0]  alu_val2,
  output logic [XLEN-1:0]  mul_val1,
  output logic [XLEN-1:0]  mul_val2
);

  localparam logic [TAG_W-1:0] ZERO_TAG = TAG_W'(NUM_PR - 1);  // last reg is hardwired zero

  logic [XLEN-1:0]  regs   [NUM_PR];  // register array
  logic [TAG_W-1:0] rd_tag [4];       // 0,1 alu  2,3 mul
  logic [XLEN-1:0]  rd_val [4];
  logic             cdb_wr;           // broadcast that actually lands in the array

  assign cdb_wr = cdb_valid && (cdb_tag != ZERO_TAG);  // zero reg never written

  assign rd_tag[0] = alu_src1;
  assign rd_tag[1] = alu_src2;
  assign rd_tag[2] = mul_src1;
  assign rd_tag[3] = mul_src2;

  // read mux with same-cycle bypass from the CDB
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      if (rd_tag[i] == ZERO_TAG) begin
        rd_val[i] = '0;                      // zero reg reads 0
      end else if (cdb_wr && (cdb_tag == rd_tag[i])) begin
        rd_val[i] = cdb_value;               // forward broadcast value
      end else begin
        rd_val[i] = regs[rd_tag[i]];
      end
    end
  end

  assign alu_val1 = rd_val[0];
  assign alu_val2 = rd_val[1];
  assign mul_val1 = rd_val[2];
  assign mul_val2 = rd_val[3];

  // write from the CDB
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < NUM_PR; i++) begin
        regs[i] <= '0;                       // all regs start at 0
      end
    end else if (en && cdb_wr) begin
      regs[cdb_tag] <= cdb_value;            // visible to reads next cycle
    end
  end

endmodule : phys_reg_file

`default_nettype wire

/* test/exec_core_tb.sv */
//****************************************
// execute core testbench
// directed and random issue, checks every CDB broadcast
//****************************************
`default_nettype none

module exec_core_tb import exec_core_pkg::*;;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_PR   = 32;
  localparam int TAG_W    = 5;
  localparam int ZERO_TAG = NUM_PR - 1;  // hardwired zero reg
  localparam int T1_ISSUES = 8;
  localparam int T2_ISSUES = 33;
  localparam int T3_ISSUES = 8;
  localparam int T4_ISSUES = 4;
  localparam int T5_ISSUES = 9;
  localparam int WATCHDOG_CYCLES =
    5 + 20 * (T1_ISSUES + T2_ISSUES + T3_ISSUES + T4_ISSUES + T5_ISSUES);

  logic             clock, reset, en;
  logic             alu_issue, mul_issue;
  alu_op_t          alu_op;
  mul_op_t          mul_op;
  logic [TAG_W-1:0] alu_dest, alu_src1, alu_src2;
  logic [TAG_W-1:0] mul_dest, mul_src1, mul_src2;
  logic [63:0]      alu_imm;
  logic             alu_ready, cdb_valid;
  logic [TAG_W-1:0] cdb_tag;
  logic [63:0]      cdb_value;

  logic [63:0] model_regs    [NUM_PR];  // committed values
  logic        pending_valid [NUM_PR];  // broadcast expected
  logic [63:0] pending_value [NUM_PR];
  int          pending_cycle [NUM_PR];  // -1 when timing is free
  int          pending_count = 0;
  int          cycle = 0;
  int          error_count = 0;
  int          check_count = 0;
  int          test_errors = 0;         // errors at test start
  logic [63:0] rng_state = 64'd51;

  exec_core #(.NUM_PR(NUM_PR)) DUT (
    .clock, .reset, .en,
    .alu_issue, .alu_op, .alu_dest, .alu_src1, .alu_src2, .alu_imm,
    .mul_issue, .mul_op, .mul_dest, .mul_src1, .mul_src2,
    .alu_ready, .cdb_valid, .cdb_tag, .cdb_value
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) cycle <= cycle + 1;  // edge counter

  // xorshift64
  function automatic logic [63:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 7);
    rng_state = rng_state ^ (rng_state << 17);
    return rng_state;
  endfunction

  // value of an op from its opcode and operands
  function automatic logic [63:0] expected_result(input logic is_mul, input alu_op_t aop,
      input mul_op_t mop, input logic [63:0] a, input logic [63:0] b, input logic [63:0] imm);
    logic [127:0] prod;
    prod = {64'd0, a} * {64'd0, b};  // unsigned full product
    if (is_mul) return (mop == MUL_HI) ? prod[127:64] : prod[63:0];
    case (aop)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLL:  return a << b[5:0];
      ALU_SRL:  return a >> b[5:0];
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
      ALU_ADDI: return a + imm;
      default:  return 64'd0;
    endcase
  endfunction

  // source value as the model sees it, broadcast this cycle included
  function automatic logic [63:0] operand(input int tag);
    if (tag == ZERO_TAG) return 64'd0;
    if (pending_valid[tag]) return pending_value[tag];
    return model_regs[tag];
  endfunction

  function automatic logic [63:0] known_constant(input int idx);
    case (idx)
      0:       return 64'd0;
      1:       return 64'd1;
      2:       return 64'hffff_ffff_ffff_ffff;
      3:       return 64'h8000_0000_0000_0000;
      4:       return 64'h0123_4567_89ab_cdef;
      5:       return 64'h0000_0000_ffff_ffff;
      6:       return 64'd63;
      default: return 64'h5a5a_a5a5_f00f_0ff0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic report_failure(input string what);
    error_count++;
    $display("Failure at %0t: %s", $time, what);
  endtask

  task automatic record_pending(input int dest, input logic [63:0] value, input int delay);
    pending_valid[dest] = 1'b1;
    pending_value[dest] = value;
    pending_cycle[dest] = (delay < 0) ? -1 : cycle + delay;  // cycle of the broadcast
    pending_count++;
  endtask

  // all tasks start and end 1 ns after a rising edge
  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic issue_alu(input alu_op_t op, input int dest, input int src1, input int src2,
                           input logic [63:0] imm, input int delay);
    check_value("alu_ready", alu_ready, 64'd1);
    record_pending(dest, expected_result(1'b0, op, MUL_LO, operand(src1), operand(src2), imm),
                   delay);
    alu_issue = 1'b1;
    alu_op    = op;
    alu_dest  = TAG_W'(dest);
    alu_src1  = TAG_W'(src1);
    alu_src2  = TAG_W'(src2);
    alu_imm   = imm;
    idle_cycles(1);
    alu_issue = 1'b0;
  endtask

  task automatic issue_mul(input mul_op_t op, input int dest, input int src1, input int src2,
                           input int delay);
    record_pending(dest, expected_result(1'b1, ALU_ADD, op, operand(src1), operand(src2), 64'd0),
                   delay);
    mul_issue = 1'b1;
    mul_op    = op;
    mul_dest  = TAG_W'(dest);
    mul_src1  = TAG_W'(src1);
    mul_src2  = TAG_W'(src2);
    idle_cycles(1);
    mul_issue = 1'b0;
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (pending_count != 0 && n < 20) begin
      idle_cycles(1);
      n++;
    end
    if (pending_count != 0) begin
      report_failure($sformatf("%0d results never reached the CDB", pending_count));
      for (int i = 0; i < NUM_PR; i++) pending_valid[i] = 1'b0;
      pending_count = 0;
    end
  endtask

  task automatic finish_test(input string name);
    wait_drained();
    $display("test %s finished with %0d errors", name, error_count - test_errors);
    test_errors = error_count;
  endtask

  // compares every broadcast with what the model expects
  always @(negedge clock) begin
    if (!reset && cdb_valid) begin
      if (!en) begin
        report_failure("CDB broadcast while en is low");
      end else if (!pending_valid[cdb_tag]) begin
        if (cdb_tag == ZERO_TAG) report_failure("zero register broadcast with no op writing it");
        else report_failure($sformatf("tag %0d broadcast with nothing pending", cdb_tag));
      end else begin
        check_value("cdb_value", cdb_value, pending_value[cdb_tag]);
        if (pending_cycle[cdb_tag] >= 0)
          check_value("cdb broadcast cycle", 64'(cycle), 64'(pending_cycle[cdb_tag]));
        if (cdb_tag != ZERO_TAG) model_regs[cdb_tag] = pending_value[cdb_tag];
        pending_valid[cdb_tag] = 1'b0;
        pending_count--;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("watchdog expired before the tests completed");
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    reset = 1'b1;
    en = 1'b1;
    alu_issue = 1'b0;
    mul_issue = 1'b0;
    alu_op = ALU_ADD;
    mul_op = MUL_LO;
    alu_dest = '0;
    alu_src1 = '0;
    alu_src2 = '0;
    alu_imm = '0;
    mul_dest = '0;
    mul_src1 = '0;
    mul_src2 = '0;
    for (int i = 0; i < NUM_PR; i++) begin
      model_regs[i] = 64'd0;
      pending_valid[i] = 1'b0;
      pending_value[i] = 64'd0;
      pending_cycle[i] = -1;
    end
    repeat (5) @(posedge clock);
    #1 reset = 1'b0;

    // reset state, then constants from the zero reg
    check_value("cdb_valid", cdb_valid, 64'd0);
    check_value("alu_ready", alu_ready, 64'd1);
    for (int i = 0; i < 8; i++) issue_alu(ALU_ADDI, i, ZERO_TAG, ZERO_TAG, known_constant(i), 1);
    finish_test("reset_and_immediates");

    // random values in 8..11, then every opcode back to back
    for (int i = 0; i < 4; i++) issue_alu(ALU_ADDI, 8 + i, ZERO_TAG, 0, next_random(), 1);
    for (int i = 0; i < 9; i++)
      issue_alu(alu_op_t'(i), 12 + i, 8 + i % 4, 8 + (i + 1) % 4, next_random(), 1);
    for (int k = 0; k < 20; k++)
      issue_alu(alu_op_t'(next_random() % 9), 12 + k % 16, int'(next_random() % 12),
                int'(next_random() % 12), next_random(), 1);
    finish_test("alu_opcodes");

    // two groups of three multiplies on consecutive cycles
    issue_alu(ALU_ADDI, 12, ZERO_TAG, 0, next_random(), 1);
    issue_alu(ALU_ADDI, 13, ZERO_TAG, 0, next_random(), 1);
    idle_cycles(1);
    issue_mul(MUL_LO, 16, 8, 9, 3);
    issue_mul(MUL_HI, 17, 10, 11, 3);
    issue_mul(MUL_LO, 18, 12, 13, 3);
    idle_cycles(3);
    issue_mul(MUL_HI, 19, 12, 13, 3);
    issue_mul(MUL_LO, 20, 11, 8, 3);
    issue_mul(MUL_HI, 21, 9, 10, 3);
    finish_test("multiplier");

    // ALU completion lands on a multiply, waits one cycle
    issue_mul(MUL_HI, 14, 12, 13, 3);
    idle_cycles(1);
    issue_alu(ALU_ADD, 15, 8, 9, 64'd0, 2);
    @(negedge clock);
    check_value("alu_ready during wait", alu_ready, 64'd0);
    idle_cycles(1);
    wait_drained();
    issue_mul(MUL_LO, 22, 10, 11, 3);
    idle_cycles(1);
    issue_alu(ALU_SUB, 23, 11, 10, 64'd0, 2);
    @(negedge clock);
    check_value("alu_ready during wait", alu_ready, 64'd0);
    idle_cycles(1);
    finish_test("arbitration");

    // chain through forwarded values, ALU and multiplier
    issue_alu(ALU_ADDI, 20, 8, 0, next_random(), 1);
    issue_alu(ALU_ADD, 21, 20, 9, 64'd0, 1);       // 20 on the CDB now
    issue_mul(MUL_LO, 22, 21, 9, 3);               // 21 on the CDB now
    idle_cycles(2);
    issue_alu(ALU_XOR, 23, 22, 8, 64'd0, 1);       // multiply result on the CDB
    wait_drained();
    // zero reg as destination still broadcasts
    issue_alu(ALU_ADDI, ZERO_TAG, 9, 0, next_random(), 1);
    issue_alu(ALU_OR, 24, ZERO_TAG, ZERO_TAG, 64'd0, 1);  // zero broadcast not forwarded
    issue_mul(MUL_LO, 25, ZERO_TAG, 9, 3);
    wait_drained();
    // freeze with results in flight
    issue_mul(MUL_HI, 26, 8, 11, -1);
    issue_alu(ALU_SLT, 27, 9, 10, 64'd0, -1);
    en = 1'b0;
    mul_issue = 1'b1;                              // ignored strobe, nothing recorded
    mul_dest = TAG_W'(28);
    repeat (5) begin
      @(negedge clock);
      check_value("cdb_valid while frozen", cdb_valid, 64'd0);
      idle_cycles(1);
      mul_issue = 1'b0;
    end
    en = 1'b1;
    finish_test("forwarding_zero_enable");
    idle_cycles(5);                                // catch a late stray broadcast

    $display("%0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule : exec_core_tb

`default_nettype wire
